/* hw/cache_pkg.sv */
package cache_pkg;

	// Cache geometry, one 32-bit word per line.
	localparam int ADDR_W    = 16;               // Word address width.
	localparam int DATA_W    = 32;
	localparam int INDEX_W   = 6;
	localparam int TAG_W     = ADDR_W - INDEX_W;
	localparam int NUM_LINES = 1 << INDEX_W;     // 64 lines.

	// Stores split the request address into tag and index.
	typedef struct packed
	{
		logic [TAG_W-1:0]   tag;
		logic [INDEX_W-1:0] index;
	} cache_fields_t;

	// The DRAM sees the flat word address.
	typedef union packed
	{
		logic [ADDR_W-1:0] raw;
		cache_fields_t     fields;
	} cache_addr_t;

	// Controller states.
	typedef enum logic [3:0]
	{
		IDLE,
		COMPARE,
		READ_MEM,
		READ_DATA,
		WRITE_HIT,
		WRITE_BACK_MEM
	} ctrl_state_t;

endpackage

/* hw/cache_if.sv */
interface cache_if;

	// Controls from the FSM to the stores.
	logic sram_we;   // Write the selected line this cycle.
	logic dirty_o;   // Dirty value to store with the line.
	logic data_sel;  // 0 selects CPU write data, 1 selects DRAM read data.

	// Line status from the tag store.
	logic hit;
	logic valid;
	logic dirty_i;

	modport ctrl
	(
		output sram_we, dirty_o, data_sel,
		input  hit, valid, dirty_i
	);

	modport tags
	(
		input  sram_we, dirty_o, data_sel,
		output hit, valid, dirty_i
	);

	modport data
	(
		input sram_we, data_sel
	);

endinterface

/* hw/cache_ctrl.sv */
module cache_ctrl (
	input  logic  clk,
	input  logic  rst,

	// CPU side.
	input  logic  cpu_cs,
	input  logic  cpu_we,
	output logic  cpu_ack,

	// Tag and data stores.
	cache_if.ctrl ctrl,

	// DRAM side.
	output logic  dram_cs,
	output logic  dram_we,
	input  logic  dram_ack
);

	cache_pkg::ctrl_state_t state;
	cache_pkg::ctrl_state_t next_state;

	logic wb_done;   // Victim already written back for this request.
	logic read_hit;  // Read hit, acked in the COMPARE cycle.
	logic state_ack; // Moore part of the CPU ack.
	logic line_hit;

	assign line_hit = ctrl.hit && ctrl.valid;
	assign read_hit = (state == cache_pkg::COMPARE) && line_hit && !cpu_we;
	assign cpu_ack  = state_ack || read_hit;

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			state   <= cache_pkg::IDLE;
			wb_done <= 1'b0;
		end
		else
		begin
			state <= next_state;
			// The line keeps its old tag and dirty bit after a write back,
			// so COMPARE has to know the victim is already in DRAM.
			if (state == cache_pkg::IDLE)
			begin
				wb_done <= 1'b0;
			end
			else if (state == cache_pkg::WRITE_BACK_MEM && dram_ack)
			begin
				wb_done <= 1'b1;
			end
		end
	end

	// Next state.
	always_comb
	begin
		next_state = state;
		case (state)
			cache_pkg::IDLE:
			begin
				if (cpu_cs)
					next_state = cache_pkg::COMPARE;
			end
			cache_pkg::COMPARE:
			begin
				if (line_hit)
					next_state = cpu_we ? cache_pkg::WRITE_HIT : cache_pkg::IDLE;
				else if (ctrl.valid && ctrl.dirty_i && !wb_done)
					next_state = cache_pkg::WRITE_BACK_MEM;  // Dirty victim first.
				else if (cpu_we)
					next_state = cache_pkg::WRITE_HIT;       // Allocate, no fetch.
				else
					next_state = cache_pkg::READ_MEM;
			end
			cache_pkg::READ_MEM:
			begin
				if (dram_ack)
					next_state = cache_pkg::READ_DATA;
			end
			cache_pkg::READ_DATA:
			begin
				next_state = cache_pkg::COMPARE;  // Hits on the next look.
			end
			cache_pkg::WRITE_HIT:
			begin
				next_state = cache_pkg::IDLE;
			end
			cache_pkg::WRITE_BACK_MEM:
			begin
				if (dram_ack)
					next_state = cache_pkg::COMPARE;
			end
			default:
			begin
				next_state = cache_pkg::IDLE;
			end
		endcase
	end

	// Moore output decode.
	always_comb
	begin
		state_ack     = 1'b0;
		ctrl.sram_we  = 1'b0;
		ctrl.dirty_o  = 1'b0;
		ctrl.data_sel = 1'b0;
		dram_cs       = 1'b0;
		dram_we       = 1'b0;
		case (state)
			cache_pkg::READ_MEM:
			begin
				dram_cs = 1'b1;  // Fetch, held until ack.
			end
			cache_pkg::READ_DATA:
			begin
				ctrl.sram_we  = 1'b1;  // Fill a clean line from DRAM.
				ctrl.data_sel = 1'b1;
			end
			cache_pkg::WRITE_HIT:
			begin
				state_ack    = 1'b1;
				ctrl.sram_we = 1'b1;
				ctrl.dirty_o = 1'b1;
			end
			cache_pkg::WRITE_BACK_MEM:
			begin
				dram_cs = 1'b1;
				dram_we = 1'b1;  // Also selects the victim address at the top.
			end
			default:
			begin
				state_ack = 1'b0;
			end
		endcase
	end

	// The top level routes the victim address only with dram_we.
	a_we_needs_cs: assert property (@(posedge clk) disable iff (!rst)
		dram_we |-> dram_cs)
		else $error("dram_we high without dram_cs");

	a_no_dram_idle: assert property (@(posedge clk) disable iff (!rst)
		(state inside {cache_pkg::IDLE, cache_pkg::COMPARE}) |-> !dram_cs)
		else $error("dram_cs high in IDLE or COMPARE");

	// The CPU drops cs after ack, so a second ack would start a phantom request.
	a_ack_pulse: assert property (@(posedge clk) disable iff (!rst)
		cpu_ack |=> !cpu_ack)
		else $error("cpu_ack held for two cycles");

endmodule

/* hw/cache_tag_store.sv */
module cache_tag_store (
	input  logic                        clk,
	input  logic                        rst,
	input  cache_pkg::cache_addr_t      addr,
	cache_if.tags                       tags,
	output logic [cache_pkg::TAG_W-1:0] victim_tag
);

	logic [cache_pkg::TAG_W-1:0]     tag_mem [cache_pkg::NUM_LINES];
	logic [cache_pkg::NUM_LINES-1:0] valid_q;
	logic [cache_pkg::NUM_LINES-1:0] dirty_q;

	logic [cache_pkg::INDEX_W-1:0] index;
	logic [cache_pkg::TAG_W-1:0]   stored_tag;

	assign index      = addr.fields.index;
	assign stored_tag = tag_mem[index];

	// Tag array, written together with the line.
	always_ff @(posedge clk)
	begin
		if (tags.sram_we)
		begin
			tag_mem[index] <= addr.fields.tag;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			valid_q <= '0;
			dirty_q <= '0;
		end
		else if (tags.sram_we)
		begin
			valid_q[index] <= 1'b1;
			dirty_q[index] <= tags.dirty_o;
		end
	end

	assign tags.valid   = valid_q[index];
	assign tags.dirty_i = dirty_q[index];
	assign tags.hit     = valid_q[index] && (stored_tag == addr.fields.tag);

	assign victim_tag = stored_tag;  // Old address for the write back.

	// A DRAM fill always leaves the line clean.
	a_fill_clean: assert property (@(posedge clk) disable iff (!rst)
		(tags.sram_we && tags.data_sel) |-> !tags.dirty_o)
		else $error("fill from DRAM marked dirty");

endmodule

/* hw/cache_data_store.sv */
module cache_data_store (
	input  logic                         clk,
	input  logic [cache_pkg::INDEX_W-1:0] index,
	cache_if.data                        data,
	input  logic [cache_pkg::DATA_W-1:0]  cpu_wdata,
	input  logic [cache_pkg::DATA_W-1:0]  dram_rdata,
	output logic [cache_pkg::DATA_W-1:0]  rdata
);

	// One word per line.
	logic [cache_pkg::DATA_W-1:0] mem [cache_pkg::NUM_LINES];
	logic [cache_pkg::DATA_W-1:0] wdata;

	// Fill from DRAM or the CPU store word.
	assign wdata = data.data_sel ? dram_rdata : cpu_wdata;

	always_ff @(posedge clk)
	begin
		if (data.sram_we)
		begin
			mem[index] <= wdata;
		end
	end

	// Asynchronous read, so a read hit returns data in COMPARE.
	// The same word is the write back data for a dirty victim.
	assign rdata = mem[index];

endmodule

/* hw/l1_cache.sv */
module l1_cache (
	input  logic                         clk,
	input  logic                         rst,

	// CPU side.
	input  logic                         cpu_cs,
	input  logic                         cpu_we,
	input  logic [cache_pkg::ADDR_W-1:0] cpu_addr,
	input  logic [cache_pkg::DATA_W-1:0] cpu_wdata,
	output logic [cache_pkg::DATA_W-1:0] cpu_rdata,
	output logic                         cpu_ack,

	// DRAM side.
	output logic                         dram_cs,
	output logic                         dram_we,
	output logic [cache_pkg::ADDR_W-1:0] dram_addr,
	output logic [cache_pkg::DATA_W-1:0] dram_wdata,
	input  logic [cache_pkg::DATA_W-1:0] dram_rdata,
	input  logic                         dram_ack
);

	cache_pkg::cache_addr_t       req_addr;
	logic [cache_pkg::TAG_W-1:0]  victim_tag;
	logic [cache_pkg::DATA_W-1:0] line_data;

	cache_if cif ();

	assign req_addr = cpu_addr;

	// Write back goes to the victim's address, fetch to the request's.
	assign dram_addr  = dram_we ? {victim_tag, req_addr.fields.index} : req_addr.raw;
	assign dram_wdata = line_data;
	assign cpu_rdata  = line_data;

	cache_ctrl u_ctrl (
		.clk      (clk),
		.rst      (rst),
		.cpu_cs   (cpu_cs),
		.cpu_we   (cpu_we),
		.cpu_ack  (cpu_ack),
		.ctrl     (cif.ctrl),
		.dram_cs  (dram_cs),
		.dram_we  (dram_we),
		.dram_ack (dram_ack)
	);

	cache_tag_store u_tags (
		.clk        (clk),
		.rst        (rst),
		.addr       (req_addr),
		.tags       (cif.tags),
		.victim_tag (victim_tag)
	);

	cache_data_store u_data (
		.clk        (clk),
		.index      (req_addr.fields.index),
		.data       (cif.data),
		.cpu_wdata  (cpu_wdata),
		.dram_rdata (dram_rdata),
		.rdata      (line_data)
	);

endmodule

/* verif/dram_model.sv */
module dram_model (
	input  logic                         clk,
	input  logic                         dram_cs,
	input  logic                         dram_we,
	input  logic [cache_pkg::ADDR_W-1:0] dram_addr,
	input  logic [cache_pkg::DATA_W-1:0] dram_wdata,
	output logic [cache_pkg::DATA_W-1:0] dram_rdata,
	output logic                         dram_ack,
	output int                           read_count,
	output int                           write_count,
	output int                           reads_at_write,
	output logic [cache_pkg::ADDR_W-1:0] last_wr_addr,
	output logic [cache_pkg::DATA_W-1:0] last_wr_data
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int DRIVE_DELAY = 2;

	logic [cache_pkg::DATA_W-1:0] mem [logic [cache_pkg::ADDR_W-1:0]];  // Only written words.
	logic [15:0] lfsr;
	logic        busy;
	int          wait_cycles;

	// Galois LFSR, one step per bit taken.
	function automatic logic take_lfsr_bit();
		logic out;
		out  = lfsr[0];
		lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
		return out;
	endfunction

	task automatic serve_access();
		if (dram_we)
		begin
			mem[dram_addr] = dram_wdata;
			reads_at_write = read_count;  // Shows whether the fetch came first.
			write_count++;
			last_wr_addr = dram_addr;
			last_wr_data = dram_wdata;
		end
		else
		begin
			if (mem.exists(dram_addr))
				dram_rdata = mem[dram_addr];
			else
				dram_rdata = 32'hA5A5_0000 ^ {16'h0000, dram_addr};  // Power-up pattern.
			read_count++;
		end
		busy     = 1'b0;
		dram_ack = 1'b1;  // Read data stays put for the fill cycle.
	endtask

	initial
	begin
		dram_ack       = 1'b0;
		dram_rdata     = '0;
		read_count     = 0;
		write_count    = 0;
		reads_at_write = 0;
		last_wr_addr   = '0;
		last_wr_data   = '0;
		lfsr           = 16'd35;
		busy           = 1'b0;
		wait_cycles    = 0;
		forever
		begin
			@(posedge clk);
			#(DRIVE_DELAY);
			if (dram_ack)
			begin
				dram_ack = 1'b0;  // Single-cycle pulse.
			end
			else
			begin
				if (dram_cs && !busy)
				begin
					busy        = 1'b1;
					wait_cycles = 1 + 2 * int'(take_lfsr_bit());  // 1 to 4 cycles.
					wait_cycles += int'(take_lfsr_bit());
				end
				if (busy)
				begin
					wait_cycles--;
					if (wait_cycles == 0)
						serve_access();
				end
			end
		end
	end

endmodule

/* verif/tb_l1_cache.sv */
module tb_l1_cache;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD    = 40;
	localparam int DRIVE_DELAY   = 2;
	localparam int RESET_CYCLES  = 4;
	localparam int MIX_REQS      = 200;
	localparam int DIRECTED_REQS = 11;
	// Twenty cycles per request, plus both resets.
	localparam int WATCHDOG_NS   =
		((MIX_REQS + DIRECTED_REQS) * 20 + 2 * RESET_CYCLES) * CLK_PERIOD;

	logic                         clk;
	logic                         rst;
	logic                         cpu_cs;
	logic                         cpu_we;
	logic [cache_pkg::ADDR_W-1:0] cpu_addr;
	logic [cache_pkg::DATA_W-1:0] cpu_wdata;
	logic [cache_pkg::DATA_W-1:0] cpu_rdata;
	logic                         cpu_ack;
	logic                         dram_cs;
	logic                         dram_we;
	logic [cache_pkg::ADDR_W-1:0] dram_addr;
	logic [cache_pkg::DATA_W-1:0] dram_wdata;
	logic [cache_pkg::DATA_W-1:0] dram_rdata;
	logic                         dram_ack;
	int                           read_count;
	int                           write_count;
	int                           reads_at_write;
	logic [cache_pkg::ADDR_W-1:0] last_wr_addr;
	logic [cache_pkg::DATA_W-1:0] last_wr_data;

	logic [31:0] shadow [logic [15:0]];  // Every CPU write lands here.
	logic [15:0] lfsr;
	int          errors;
	int          checks;

	l1_cache uut (.*);

	dram_model dram (.*);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, a request never got its ack.", WATCHDOG_NS);
		$display("Result: FAILED");
		$finish;
	end

	function automatic logic [31:0] random_bits(int n);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < n; i++)
		begin
			value = {value[30:0], lfsr[0]};
			lfsr  = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
		end
		return value;
	endfunction

	function automatic logic [31:0] expected_word(logic [15:0] addr);
		if (shadow.exists(addr))
			return shadow[addr];
		return 32'hA5A5_0000 ^ {16'h0000, addr};  // Untouched DRAM word.
	endfunction

	task automatic check_word(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		assert (actual === expected)
		else
		begin
			$display("** Error at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
			errors++;
		end
	endtask

	task automatic apply_reset();
		rst = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#(DRIVE_DELAY);
		rst = 1'b1;
	endtask

	// Starts and ends just after a rising edge. Cycles counts edges up to the one that sees ack.
	task automatic cpu_access(input logic we, input logic [15:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output int cycles);
		logic acked;
		acked     = 1'b0;
		cycles    = 0;
		cpu_cs    = 1'b1;
		cpu_we    = we;
		cpu_addr  = addr;
		cpu_wdata = wdata;
		while (!acked)
		begin
			@(negedge clk);
			acked = cpu_ack;
			rdata = cpu_rdata;
			@(posedge clk);
			cycles++;
		end
		#(DRIVE_DELAY);
		cpu_cs = 1'b0;
		cpu_we = 1'b0;
		if (we)
			shadow[addr] = wdata;
		@(negedge clk);
		checks++;
		assert (!cpu_ack)
		else
		begin
			$display("cpu_ack stayed high for a second cycle at %0d ns", $time);
			errors++;
		end
		@(posedge clk);
		#(DRIVE_DELAY);
	endtask

	task automatic cold_read_miss();
		logic [31:0] data;
		int          cycles;
		cpu_access(1'b0, 16'h0123, 32'h0, data, cycles);
		check_word("cpu_rdata", 32'hA5A5_0123, data);
		check_word("dram reads", 1, read_count);
		check_word("dram writes", 0, write_count);
	endtask

	task automatic read_hit_repeat();
		logic [31:0] data;
		int          cycles;
		cpu_access(1'b0, 16'h0123, 32'h0, data, cycles);
		check_word("cpu_rdata", 32'hA5A5_0123, data);
		check_word("read hit latency", 2, cycles);
		check_word("dram reads", 1, read_count);
		check_word("dram writes", 0, write_count);
	endtask

	task automatic write_then_read();
		logic [31:0] data;
		int          cycles;
		int          rd0;
		int          wr0;
		rd0 = read_count;
		wr0 = write_count;
		cpu_access(1'b0, 16'h0487, 32'h0, data, cycles);        // Clean line at index 7.
		cpu_access(1'b1, 16'h0887, 32'h0887_C0DE, data, cycles); // Clean victim is dropped.
		cpu_access(1'b1, 16'h0245, 32'h1111_0245, data, cycles); // Miss on an empty line.
		cpu_access(1'b1, 16'h0245, 32'h2222_0245, data, cycles);
		check_word("write hit latency", 3, cycles);
		cpu_access(1'b0, 16'h0245, 32'h0, data, cycles);
		check_word("cpu_rdata", expected_word(16'h0245), data);
		check_word("dram reads", rd0 + 1, read_count);
		check_word("dram writes", wr0, write_count);
	endtask

	task automatic dirty_eviction();
		logic [31:0] data;
		int          cycles;
		int          rd0;
		int          wr0;
		rd0 = read_count;
		wr0 = write_count;
		cpu_access(1'b0, 16'h0645, 32'h0, data, cycles);  // Same index as 0245.
		check_word("cpu_rdata", expected_word(16'h0645), data);
		check_word("dram writes", wr0 + 1, write_count);
		check_word("dram reads", rd0 + 1, read_count);
		check_word("dram_addr of write back", 32'h0000_0245, 32'(last_wr_addr));
		check_word("dram_wdata of write back", 32'h2222_0245, last_wr_data);
		check_word("dram reads before write back", rd0, reads_at_write);
		cpu_access(1'b0, 16'h0245, 32'h0, data, cycles);
		check_word("cpu_rdata", 32'h2222_0245, data);
		check_word("dram reads", rd0 + 2, read_count);
	endtask

	// Indices 0x30 to 0x33 and tags 1 to 3 stay clear of the earlier lines.
	task automatic mixed_sequence();
		logic [31:0] data;
		logic [31:0] wdata;
		logic [15:0] addr;
		logic        we;
		int          cycles;
		int          tag;
		int          idx;
		for (int n = 0; n < MIX_REQS; n++)
		begin
			we    = (random_bits(1) == 32'd1);
			tag   = 1 + int'(random_bits(2) % 3);
			idx   = 48 + int'(random_bits(2));
			addr  = 16'(tag * 64 + idx);
			wdata = random_bits(32);
			cpu_access(we, addr, wdata, data, cycles);
			if (!we)
				check_word("cpu_rdata", expected_word(addr), data);
		end
	endtask

	task automatic reset_clears_lines();
		logic [31:0] data;
		int          cycles;
		int          rd0;
		rd0 = read_count;
		cpu_access(1'b0, 16'h0123, 32'h0, data, cycles);  // Still cached.
		check_word("dram reads", rd0, read_count);
		apply_reset();
		cpu_access(1'b0, 16'h0123, 32'h0, data, cycles);
		check_word("cpu_rdata", 32'hA5A5_0123, data);
		check_word("dram reads", rd0 + 1, read_count);
	endtask

	initial
	begin
		rst       = 1'b0;
		cpu_cs    = 1'b0;
		cpu_we    = 1'b0;
		cpu_addr  = '0;
		cpu_wdata = '0;
		lfsr      = 16'd35;
		errors    = 0;
		checks    = 0;
		apply_reset();
		cold_read_miss();
		read_hit_repeat();
		write_then_read();
		dirty_eviction();
		mixed_sequence();
		reset_clears_lines();  // Last, since reset drops dirty lines.
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

/* files.f */
hw/cache_pkg.sv
hw/cache_if.sv
hw/cache_ctrl.sv
hw/cache_tag_store.sv
hw/cache_data_store.sv
hw/l1_cache.sv
verif/dram_model.sv
verif/tb_l1_cache.sv

/* run.sh */
#!/usr/bin/env bash
# Compile and run the L1 cache testbench with Verilator, then scan the log.
cd "$(dirname "$0")" || exit 1
LOG=sim.log
verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module tb_l1_cache -f files.f \
	&& ./obj_dir/Vtb_l1_cache > "$LOG" 2>&1 \
	|| { cat "$LOG" 2>/dev/null; echo "Build or run aborted"; exit 1; }
cat "$LOG"
grep -q "Result: FAILED" "$LOG" \
	&& { echo "Simulation reported a failure"; exit 1; } \
	|| { echo "Simulation finished clean"; exit 0; }
